// ==== vmul_lane_pkg.sv ====
// Shared word, instruction and register-file write types, plus element and byte-enable helpers
package vmul_lane_pkg;

  localparam int unsigned ElenBits = 64;
  localparam int unsigned StrbBits = ElenBits / 8;
  localparam int unsigned NrVInsn  = 8;

  typedef logic [ElenBits-1:0]        elen_t;
  typedef logic [StrbBits-1:0]        strb_t;
  typedef logic [$clog2(NrVInsn)-1:0] vid_t;
  // Up to 1024 elements
  typedef logic [10:0]                vlen_t;

  typedef enum logic [1:0] {
    EW8  = 2'd0,
    EW16 = 2'd1,
    EW32 = 2'd2,
    EW64 = 2'd3
  } vew_e;

  typedef enum logic [1:0] {
    VMUL   = 2'd0,
    VMULHU = 2'd1,
    VMACC  = 2'd2
  } vmul_op_e;

  typedef struct packed {
    vid_t       id;
    vmul_op_e   op;
    vew_e       vew;
    vlen_t      vl;
    logic [4:0] vd;
    logic       use_scalar;
    elen_t      scalar;
    // Set for unmasked execution
    logic       vm;
  } vmul_insn_t;

  typedef struct packed {
    vid_t       id;
    logic [7:0] addr;
    elen_t      wdata;
    strb_t      be;
  } wb_payload_t;

  // 8 elements per word at EW8 down to 1 at EW64
  function automatic logic [3:0] elems_per_word(vew_e vew);
    return 4'(8 >> int'(vew));
  endfunction

  // Enables the low bytes covered by cnt elements of width vew
  function automatic strb_t word_be(logic [3:0] cnt, vew_e vew);
    int unsigned nr_bytes;
    strb_t       be;
    nr_bytes = int'(cnt) << int'(vew);
    for (int b = 0; b < StrbBits; b++) begin
      be[b] = (b < nr_bytes);
    end
    return be;
  endfunction

endpackage

// ==== vinsn_queue.sv ====
// Circular instruction queue with accept, issue, processing and commit pointers
`timescale 1ns/1ns

module vinsn_queue import vmul_lane_pkg::*; #(
  parameter int unsigned InsnQueueDepth = 4
) (
  input  logic       clk_i,
  input  logic       rst_ni,
  input  vmul_insn_t insn_i,
  input  logic       insn_valid_i,
  output logic       insn_ready_o,
  output vmul_insn_t issue_insn_o,
  output logic       issue_valid_o,
  input  logic       issue_done_i,
  output vmul_insn_t proc_insn_o,
  input  logic       proc_done_i,
  output vmul_insn_t commit_insn_o,
  output logic       commit_valid_o,
  input  logic       commit_done_i
);

  localparam int unsigned PtrW = (InsnQueueDepth > 1) ? $clog2(InsnQueueDepth) : 1;

  typedef logic [PtrW-1:0] ptr_t;
  typedef logic [PtrW:0]   cnt_t;

  vmul_insn_t insn_q [InsnQueueDepth];
  ptr_t       accept_pnt_q, issue_pnt_q, proc_pnt_q, commit_pnt_q;
  cnt_t       issue_cnt_q, proc_cnt_q, commit_cnt_q;
  logic       accept;

  function automatic ptr_t next_pnt(ptr_t pnt);
    return (pnt == ptr_t'(InsnQueueDepth - 1)) ? '0 : pnt + 1'b1;
  endfunction

  // A slot stays taken until its instruction has committed
  assign insn_ready_o = (commit_cnt_q != cnt_t'(InsnQueueDepth));
  assign accept       = insn_valid_i && insn_ready_o;

  assign issue_insn_o   = insn_q[issue_pnt_q];
  assign issue_valid_o  = (issue_cnt_q != '0);
  assign proc_insn_o    = insn_q[proc_pnt_q];
  assign commit_insn_o  = insn_q[commit_pnt_q];
  assign commit_valid_o = (commit_cnt_q != '0);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      insn_q       <= '{default: '0};
      accept_pnt_q <= '0;
      issue_pnt_q  <= '0;
      proc_pnt_q   <= '0;
      commit_pnt_q <= '0;
      issue_cnt_q  <= '0;
      proc_cnt_q   <= '0;
      commit_cnt_q <= '0;
    end else begin
      if (accept) begin
        insn_q[accept_pnt_q] <= insn_i;
        accept_pnt_q         <= next_pnt(accept_pnt_q);
      end
      if (issue_done_i) issue_pnt_q <= next_pnt(issue_pnt_q);
      if (proc_done_i) proc_pnt_q <= next_pnt(proc_pnt_q);
      if (commit_done_i) commit_pnt_q <= next_pnt(commit_pnt_q);
      issue_cnt_q  <= issue_cnt_q + cnt_t'(accept) - cnt_t'(issue_done_i);
      proc_cnt_q   <= proc_cnt_q + cnt_t'(accept) - cnt_t'(proc_done_i);
      commit_cnt_q <= commit_cnt_q + cnt_t'(accept) - cnt_t'(commit_done_i);
    end
  end

  // Issue, writeback and register-file side must never retire a phase that is empty
  a_done_needs_insn: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (issue_done_i -> issue_cnt_q != '0) &&
    (proc_done_i -> proc_cnt_q != '0) &&
    (commit_done_i -> commit_cnt_q != '0));

endmodule

// ==== vmul_issue.sv ====
// Operand handshake, scalar replication and per-word issue to the SIMD multipliers
`timescale 1ns/1ns

module vmul_issue import vmul_lane_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  vmul_insn_t  issue_insn_i,
  input  logic        issue_valid_i,
  output logic        issue_done_o,
  input  elen_t [2:0] operand_i,
  input  logic  [2:0] operand_valid_i,
  output logic  [2:0] operand_ready_o,
  input  strb_t       mask_i,
  input  logic        mask_valid_i,
  output logic        mask_ready_o,
  output elen_t       mul_a_o,
  output elen_t       mul_b_o,
  output elen_t       mul_c_o,
  output vmul_op_e    mul_op_o,
  output strb_t       mul_be_o,
  output logic  [3:0] mul_valid_o,
  input  logic  [3:0] mul_ready_i
);

  vlen_t      cnt_q;
  vlen_t      remaining;
  vlen_t      remaining_next;
  logic       first_q;
  logic [3:0] word_elems;
  logic [3:0] nr_elems;
  logic [2:0] used;
  logic       ops_valid;
  logic       fire;
  elen_t      scalar_rep;

  // A fresh instruction starts from its full vl
  assign remaining      = first_q ? issue_insn_i.vl : cnt_q;
  assign word_elems     = elems_per_word(issue_insn_i.vew);
  assign nr_elems       = (remaining < vlen_t'(word_elems)) ? remaining[3:0] : word_elems;
  assign remaining_next = remaining - vlen_t'(nr_elems);

  // Queue order is vs1, vs2, vd
  assign used      = {issue_insn_i.op == VMACC, 1'b1, !issue_insn_i.use_scalar};
  assign ops_valid = (&(operand_valid_i | ~used)) && (mask_valid_i || issue_insn_i.vm);
  assign fire      = issue_valid_i && ops_valid && mul_ready_i[issue_insn_i.vew];

  always_comb begin
    mul_valid_o                   = '0;
    mul_valid_o[issue_insn_i.vew] = issue_valid_i && ops_valid;
  end

  assign operand_ready_o = fire ? used : 3'b000;
  assign mask_ready_o    = fire && !issue_insn_i.vm;
  assign issue_done_o    = fire && (remaining_next == '0);

  always_comb begin
    case (issue_insn_i.vew)
      EW8:     scalar_rep = {8{issue_insn_i.scalar[7:0]}};
      EW16:    scalar_rep = {4{issue_insn_i.scalar[15:0]}};
      EW32:    scalar_rep = {2{issue_insn_i.scalar[31:0]}};
      default: scalar_rep = issue_insn_i.scalar;
    endcase
  end

  assign mul_a_o  = issue_insn_i.use_scalar ? scalar_rep : operand_i[0];
  assign mul_b_o  = operand_i[1];
  assign mul_c_o  = operand_i[2];
  assign mul_op_o = issue_insn_i.op;
  // Tail elements are dropped here, masked ones too
  assign mul_be_o = word_be(nr_elems, issue_insn_i.vew) &
                    (issue_insn_i.vm ? {StrbBits{1'b1}} : mask_i);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      first_q <= 1'b1;
      cnt_q   <= '0;
    end else if (fire) begin
      first_q <= issue_done_o;
      cnt_q   <= remaining_next;
    end
  end

  // A word offered to a multiplier stays put until that multiplier takes it
  a_mul_held: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (|mul_valid_o) && !fire |=>
      $stable(mul_valid_o) && $stable(mul_a_o) && $stable(mul_be_o));

endmodule

// ==== simd_mul.sv ====
// Elastic pipelined SIMD multiplier for a single element width
`timescale 1ns/1ns

module simd_mul import vmul_lane_pkg::*; #(
  parameter vew_e        Vew       = EW64,
  parameter int unsigned NumStages = 1
) (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  elen_t    a_i,
  input  elen_t    b_i,
  input  elen_t    c_i,
  input  vmul_op_e op_i,
  input  strb_t    tag_i,
  input  logic     valid_i,
  output logic     ready_o,
  output elen_t    result_o,
  output strb_t    tag_o,
  output logic     valid_o,
  input  logic     ready_i
);

  localparam int unsigned W = 8 << int'(Vew);
  localparam int unsigned N = ElenBits / W;

  typedef struct packed {
    elen_t result;
    strb_t tag;
  } stage_t;

  elen_t                result_d;
  stage_t               data_q [NumStages];
  logic [NumStages-1:0] valid_q;
  logic [NumStages:0]   stage_ready;

  for (genvar e = 0; e < N; e++) begin : gen_elem
    logic [W-1:0]   a_e;
    logic [W-1:0]   b_e;
    logic [W-1:0]   c_e;
    logic [2*W-1:0] prod;

    assign a_e  = a_i[e*W +: W];
    assign b_e  = b_i[e*W +: W];
    assign c_e  = c_i[e*W +: W];
    assign prod = a_e * b_e;
    // Accumulate wraps at the element width
    assign result_d[e*W +: W] = (op_i == VMULHU) ? prod[2*W-1:W] :
                                (op_i == VMACC)  ? c_e + prod[W-1:0] : prod[W-1:0];
  end

  // A stage accepts when empty or when its content moves on
  always_comb begin
    stage_ready[NumStages] = ready_i;
    for (int s = NumStages - 1; s >= 0; s--) begin
      stage_ready[s] = !valid_q[s] || stage_ready[s+1];
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= '0;
    end else begin
      if (stage_ready[0]) valid_q[0] <= valid_i;
      for (int s = 1; s < NumStages; s++) begin
        if (stage_ready[s]) valid_q[s] <= valid_q[s-1];
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (valid_i && stage_ready[0]) data_q[0] <= '{result: result_d, tag: tag_i};
    for (int s = 1; s < NumStages; s++) begin
      if (valid_q[s-1] && stage_ready[s]) data_q[s] <= data_q[s-1];
    end
  end

  assign ready_o  = stage_ready[0];
  assign valid_o  = valid_q[NumStages-1];
  assign result_o = data_q[NumStages-1].result;
  assign tag_o    = data_q[NumStages-1].tag;

  a_result_held: assert property (@(posedge clk_i) disable iff (!rst_ni)
    valid_o && !ready_i |=> valid_o && $stable(result_o));

endmodule

// ==== result_queue.sv ====
// Small in-order FIFO for any packed payload
`timescale 1ns/1ns

module result_queue #(
  parameter int unsigned Depth     = 2,
  parameter type         payload_t = logic
) (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  payload_t data_i,
  input  logic     valid_i,
  output logic     ready_o,
  output payload_t data_o,
  output logic     valid_o,
  input  logic     ready_i
);

  localparam int unsigned PtrW = (Depth > 1) ? $clog2(Depth) : 1;

  payload_t        mem_q [Depth];
  logic [PtrW-1:0] wr_pnt_q, rd_pnt_q;
  logic [PtrW:0]   cnt_q;
  logic            push;
  logic            pop;

  assign ready_o = (cnt_q != (PtrW+1)'(Depth));
  assign valid_o = (cnt_q != '0);
  assign data_o  = mem_q[rd_pnt_q];
  assign push    = valid_i && ready_o;
  assign pop     = valid_o && ready_i;

  always_ff @(posedge clk_i) begin
    if (push) mem_q[wr_pnt_q] <= data_i;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_pnt_q <= '0;
      rd_pnt_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (push) wr_pnt_q <= (wr_pnt_q == PtrW'(Depth - 1)) ? '0 : wr_pnt_q + 1'b1;
      if (pop) rd_pnt_q <= (rd_pnt_q == PtrW'(Depth - 1)) ? '0 : rd_pnt_q + 1'b1;
      cnt_q <= cnt_q + (PtrW+1)'(push) - (PtrW+1)'(pop);
    end
  end

  a_cnt_bound: assert property (@(posedge clk_i) disable iff (!rst_ni)
    cnt_q <= (PtrW+1)'(Depth));

endmodule

// ==== vmul_writeback.sv ====
// In-order result collection, register-file address generation and commit tracking
`timescale 1ns/1ns

module vmul_writeback import vmul_lane_pkg::*; #(
  parameter int unsigned RegWords = 8
) (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  vmul_insn_t         proc_insn_i,
  output logic               proc_done_o,
  input  vmul_insn_t         commit_insn_i,
  input  logic               commit_valid_i,
  output logic               commit_done_o,
  input  elen_t  [3:0]       mul_result_i,
  input  strb_t  [3:0]       mul_tag_i,
  input  logic   [3:0]       mul_valid_i,
  output logic   [3:0]       mul_ready_o,
  output wb_payload_t        push_o,
  output logic               push_valid_o,
  input  logic               push_ready_i,
  input  logic               wb_fire_i,
  output logic [NrVInsn-1:0] done_o
);

  vlen_t      proc_cnt_q, proc_rem, proc_rem_next;
  vlen_t      commit_cnt_q, commit_rem, commit_rem_next;
  vlen_t      proc_word;
  logic       proc_first_q, commit_first_q;
  logic [3:0] proc_epw, proc_elems;
  logic [3:0] commit_epw, commit_elems;
  logic       proc_fire;

  // Processing side
  assign proc_rem      = proc_first_q ? proc_insn_i.vl : proc_cnt_q;
  assign proc_epw      = elems_per_word(proc_insn_i.vew);
  assign proc_elems    = (proc_rem < vlen_t'(proc_epw)) ? proc_rem[3:0] : proc_epw;
  assign proc_rem_next = proc_rem - vlen_t'(proc_elems);
  assign proc_word     = (proc_insn_i.vl - proc_rem) >> (3 - int'(proc_insn_i.vew));

  // Only the multiplier of the processing width is read
  always_comb begin
    mul_ready_o                  = '0;
    mul_ready_o[proc_insn_i.vew] = push_ready_i;
  end

  assign push_valid_o = mul_valid_i[proc_insn_i.vew];
  assign proc_fire    = push_valid_o && push_ready_i;
  assign proc_done_o  = proc_fire && (proc_rem_next == '0);

  always_comb begin
    push_o.id    = proc_insn_i.id;
    push_o.addr  = 8'(proc_insn_i.vd * RegWords + proc_word);
    push_o.wdata = mul_result_i[proc_insn_i.vew];
    push_o.be    = word_be(proc_elems, proc_insn_i.vew) &
                   (proc_insn_i.vm ? {StrbBits{1'b1}} : mul_tag_i[proc_insn_i.vew]);
  end

  // Commit side counts words accepted by the register file
  assign commit_rem      = commit_first_q ? commit_insn_i.vl : commit_cnt_q;
  assign commit_epw      = elems_per_word(commit_insn_i.vew);
  assign commit_elems    = (commit_rem < vlen_t'(commit_epw)) ? commit_rem[3:0] : commit_epw;
  assign commit_rem_next = commit_rem - vlen_t'(commit_elems);
  assign commit_done_o   = commit_valid_i && wb_fire_i && (commit_rem_next == '0);

  always_comb begin
    done_o                   = '0;
    done_o[commit_insn_i.id] = commit_done_o;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      proc_first_q   <= 1'b1;
      proc_cnt_q     <= '0;
      commit_first_q <= 1'b1;
      commit_cnt_q   <= '0;
    end else begin
      if (proc_fire) begin
        proc_first_q <= proc_done_o;
        proc_cnt_q   <= proc_rem_next;
      end
      if (wb_fire_i) begin
        commit_first_q <= commit_done_o;
        commit_cnt_q   <= commit_rem_next;
      end
    end
  end

endmodule

// ==== vmul_lane.sv ====
// Vector multiply lane top with queue, issue, SIMD multipliers, result FIFO and writeback
`timescale 1ns/1ns

module vmul_lane import vmul_lane_pkg::*; #(
  parameter int unsigned InsnQueueDepth   = 4,
  parameter int unsigned ResultQueueDepth = 2,
  parameter int unsigned RegWords         = 8,
  parameter int unsigned Lat8             = 1,
  parameter int unsigned Lat16            = 1,
  parameter int unsigned Lat32            = 2,
  parameter int unsigned Lat64            = 2
) (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  vmul_insn_t         insn_i,
  input  logic               insn_valid_i,
  output logic               insn_ready_o,
  input  elen_t  [2:0]       operand_i,
  input  logic   [2:0]       operand_valid_i,
  output logic   [2:0]       operand_ready_o,
  input  strb_t              mask_i,
  input  logic               mask_valid_i,
  output logic               mask_ready_o,
  output wb_payload_t        wb_o,
  output logic               wb_valid_o,
  input  logic               wb_ready_i,
  output logic [NrVInsn-1:0] done_o
);

  // Indexed by element width code
  localparam int unsigned MulLat [4] = '{Lat8, Lat16, Lat32, Lat64};

  vmul_insn_t  issue_insn, proc_insn, commit_insn;
  logic        issue_valid, issue_done, proc_done, commit_valid, commit_done;
  elen_t       mul_a, mul_b, mul_c;
  vmul_op_e    mul_op;
  strb_t       mul_be;
  logic  [3:0] mul_in_valid, mul_in_ready, mul_out_valid, mul_out_ready;
  elen_t [3:0] mul_result;
  strb_t [3:0] mul_tag;
  wb_payload_t push;
  logic        push_valid, push_ready;
  logic        wb_fire;

  assign wb_fire = wb_valid_o && wb_ready_i;

  vinsn_queue #(
    .InsnQueueDepth(InsnQueueDepth)
  ) i_vinsn_queue (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .insn_i        (insn_i),
    .insn_valid_i  (insn_valid_i),
    .insn_ready_o  (insn_ready_o),
    .issue_insn_o  (issue_insn),
    .issue_valid_o (issue_valid),
    .issue_done_i  (issue_done),
    .proc_insn_o   (proc_insn),
    .proc_done_i   (proc_done),
    .commit_insn_o (commit_insn),
    .commit_valid_o(commit_valid),
    .commit_done_i (commit_done)
  );

  vmul_issue i_vmul_issue (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .issue_insn_i   (issue_insn),
    .issue_valid_i  (issue_valid),
    .issue_done_o   (issue_done),
    .operand_i      (operand_i),
    .operand_valid_i(operand_valid_i),
    .operand_ready_o(operand_ready_o),
    .mask_i         (mask_i),
    .mask_valid_i   (mask_valid_i),
    .mask_ready_o   (mask_ready_o),
    .mul_a_o        (mul_a),
    .mul_b_o        (mul_b),
    .mul_c_o        (mul_c),
    .mul_op_o       (mul_op),
    .mul_be_o       (mul_be),
    .mul_valid_o    (mul_in_valid),
    .mul_ready_i    (mul_in_ready)
  );

  for (genvar g = 0; g < 4; g++) begin : gen_mul
    simd_mul #(
      .Vew      (vew_e'(g)),
      .NumStages(MulLat[g])
    ) i_simd_mul (
      .clk_i   (clk_i),
      .rst_ni  (rst_ni),
      .a_i     (mul_a),
      .b_i     (mul_b),
      .c_i     (mul_c),
      .op_i    (mul_op),
      .tag_i   (mul_be),
      .valid_i (mul_in_valid[g]),
      .ready_o (mul_in_ready[g]),
      .result_o(mul_result[g]),
      .tag_o   (mul_tag[g]),
      .valid_o (mul_out_valid[g]),
      .ready_i (mul_out_ready[g])
    );
  end

  vmul_writeback #(
    .RegWords(RegWords)
  ) i_vmul_writeback (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .proc_insn_i   (proc_insn),
    .proc_done_o   (proc_done),
    .commit_insn_i (commit_insn),
    .commit_valid_i(commit_valid),
    .commit_done_o (commit_done),
    .mul_result_i  (mul_result),
    .mul_tag_i     (mul_tag),
    .mul_valid_i   (mul_out_valid),
    .mul_ready_o   (mul_out_ready),
    .push_o        (push),
    .push_valid_o  (push_valid),
    .push_ready_i  (push_ready),
    .wb_fire_i     (wb_fire),
    .done_o        (done_o)
  );

  result_queue #(
    .Depth    (ResultQueueDepth),
    .payload_t(wb_payload_t)
  ) i_result_queue (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .data_i (push),
    .valid_i(push_valid),
    .ready_o(push_ready),
    .data_o (wb_o),
    .valid_o(wb_valid_o),
    .ready_i(wb_ready_i)
  );

endmodule

// ==== vmul_lane_checker.sv ====
// Testbench checker with reference model, expected-write queue and done-pulse comparison
`timescale 1ns/1ns

module vmul_lane_checker import vmul_lane_pkg::*; #(
  parameter int unsigned InsnQueueDepth = 4,
  parameter int unsigned RegWords       = 8
) (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  vmul_insn_t         insn_i,
  input  logic               insn_valid_i,
  input  logic               insn_ready_i,
  input  elen_t  [2:0]       operand_i,
  input  logic   [2:0]       operand_valid_i,
  input  logic   [2:0]       operand_ready_i,
  input  strb_t              mask_i,
  input  logic               mask_valid_i,
  input  logic               mask_ready_i,
  input  wb_payload_t        wb_i,
  input  logic               wb_valid_i,
  input  logic               wb_ready_i,
  input  logic [NrVInsn-1:0] done_i,
  output int unsigned        err_cnt_o,
  output int unsigned        word_cnt_o,
  output int unsigned        done_cnt_o,
  output int unsigned        full_cycles_o,
  output int unsigned        pending_o
);

  typedef struct packed {
    wb_payload_t wb;
    logic        last;
  } exp_t;

  string       test_name = "reset";
  vmul_insn_t  issue_q [$];
  exp_t        exp_q [$];
  int unsigned issue_word  = 0;
  int unsigned in_flight   = 0;
  int unsigned err_cnt     = 0;
  int unsigned word_cnt    = 0;
  int unsigned done_cnt    = 0;
  int unsigned full_cycles = 0;
  int unsigned pending     = 0;

  assign err_cnt_o     = err_cnt;
  assign word_cnt_o    = word_cnt;
  assign done_cnt_o    = done_cnt;
  assign full_cycles_o = full_cycles;
  assign pending_o     = pending;

  function automatic int unsigned words_of(vmul_insn_t insn);
    int unsigned epw;
    epw = 8 >> int'(insn.vew);
    return (int'(insn.vl) + epw - 1) / epw;
  endfunction

  // Expected register-file write for one word, built element by element
  function automatic exp_t expected_write(vmul_insn_t insn, int unsigned word, elen_t vs1,
                                          elen_t vs2, elen_t vd, strb_t mask);
    int unsigned  w;
    int unsigned  epw;
    int unsigned  rem;
    int unsigned  elems;
    int           be_full;
    logic [127:0] lane_mask;
    logic [127:0] a;
    logic [127:0] b;
    logic [127:0] c;
    logic [127:0] prod;
    logic [127:0] res;
    exp_t         exp;
    w         = 8 << int'(insn.vew);
    epw       = 64 / w;
    rem       = int'(insn.vl) - word * epw;
    elems     = (rem < epw) ? rem : epw;
    lane_mask = (128'd1 << w) - 1;
    exp.wb.wdata = '0;
    for (int e = 0; e < epw; e++) begin
      a    = insn.use_scalar ? (insn.scalar & lane_mask) : ((vs1 >> (e * w)) & lane_mask);
      b    = (vs2 >> (e * w)) & lane_mask;
      c    = (vd >> (e * w)) & lane_mask;
      prod = a * b;
      case (insn.op)
        VMULHU:  res = (prod >> w) & lane_mask;
        VMACC:   res = (c + prod) & lane_mask;
        default: res = prod & lane_mask;
      endcase
      exp.wb.wdata = exp.wb.wdata | elen_t'(res << (e * w));
    end
    be_full   = (1 << (elems * w / 8)) - 1;
    exp.wb.be = strb_t'(be_full);
    if (!insn.vm) exp.wb.be = exp.wb.be & mask;
    exp.wb.id   = insn.id;
    exp.wb.addr = 8'(insn.vd * RegWords + word);
    exp.last    = (word == words_of(insn) - 1);
    return exp;
  endfunction

  always @(posedge clk_i) begin : monitor
    vmul_insn_t         insn;
    exp_t               exp;
    logic [2:0]         used;
    logic               issue_fire;
    elen_t              byte_mask;
    logic [NrVInsn-1:0] done_exp;
    issue_fire = operand_valid_i[1] && operand_ready_i[1];
    if (!rst_ni) begin
      if (!insn_ready_i || operand_ready_i != '0 || mask_ready_i || wb_valid_i || done_i != '0) begin
        $display("ERROR: outputs are not at their reset values during reset");
        err_cnt++;
      end
    end else begin
      // Queue fullness is judged by instructions not yet committed
      if (insn_ready_i != (in_flight < InsnQueueDepth)) begin
        $display("ERROR: insn_ready_o is %b with %0d instructions in flight", insn_ready_i,
                 in_flight);
        err_cnt++;
      end
      if (!insn_ready_i) full_cycles++;

      if (!issue_fire && (((operand_valid_i & operand_ready_i) != '0) ||
                          (mask_valid_i && mask_ready_i))) begin
        $display("ERROR: an operand or mask word was taken outside an issue");
        err_cnt++;
      end
      if (issue_fire && issue_q.size() == 0) begin
        $display("ERROR: operands were taken with no instruction waiting to issue");
        err_cnt++;
      end else if (issue_fire) begin
        insn = issue_q[0];
        used = {insn.op == VMACC, 1'b1, !insn.use_scalar};
        if (operand_ready_i != used || mask_ready_i != !insn.vm) begin
          $display("ERROR: instruction %0d took the wrong operand queues (%b, mask %b)",
                   insn.id, operand_ready_i, mask_ready_i);
          err_cnt++;
        end
        if ((operand_valid_i & used) != used || (!insn.vm && !mask_valid_i)) begin
          $display("ERROR: instruction %0d issued without valid operands", insn.id);
          err_cnt++;
        end
        exp_q.push_back(expected_write(insn, issue_word, operand_i[0], operand_i[1],
                                       operand_i[2], mask_i));
        issue_word++;
        if (issue_word == words_of(insn)) begin
          issue_word = 0;
          void'(issue_q.pop_front());
        end
      end

      if (insn_valid_i && insn_ready_i) begin
        issue_q.push_back(insn_i);
        in_flight++;
      end

      if (wb_valid_i && wb_ready_i && exp_q.size() == 0) begin
        $display("ERROR: register-file write at address %0d with no result expected", wb_i.addr);
        err_cnt++;
      end else if (wb_valid_i && wb_ready_i) begin
        exp = exp_q.pop_front();
        word_cnt++;
        for (int b = 0; b < StrbBits; b++) begin
          byte_mask[b*8 +: 8] = {8{exp.wb.be[b]}};
        end
        if (wb_i.id != exp.wb.id || wb_i.addr != exp.wb.addr || wb_i.be != exp.wb.be ||
            ((wb_i.wdata ^ exp.wb.wdata) & byte_mask) != '0) begin
          $display("MISMATCH %s: expected id %0d addr %0d be %b data %h, actual id %0d addr %0d be %b data %h",
                   test_name, exp.wb.id, exp.wb.addr, exp.wb.be, exp.wb.wdata & byte_mask,
                   wb_i.id, wb_i.addr, wb_i.be, wb_i.wdata & byte_mask);
          err_cnt++;
        end
        done_exp = '0;
        if (exp.last) begin
          done_exp[exp.wb.id] = 1'b1;
          done_cnt++;
          in_flight--;
        end
        if (done_i != done_exp) begin
          $display("MISMATCH %s: expected done %b, actual done %b", test_name, done_exp, done_i);
          err_cnt++;
        end
      end else if (done_i != '0) begin
        $display("ERROR: done_o pulsed (%b) without a register-file write", done_i);
        err_cnt++;
      end
    end
    pending = exp_q.size() + issue_q.size();
  end

endmodule

// ==== tb_vmul_lane.sv ====
// Testbench top with clock, reset, instruction stimulus, operand feeders and back-pressure
`timescale 1ns/1ns

module tb_vmul_lane import vmul_lane_pkg::*; ();

  localparam int unsigned InsnQueueDepth = 4;
  localparam int unsigned RegWords       = 8;

  logic               clk_i;
  logic               rst_ni;
  vmul_insn_t         insn_i;
  logic               insn_valid_i;
  logic               insn_ready_o;
  elen_t  [2:0]       operand_i;
  logic   [2:0]       operand_valid_i;
  logic   [2:0]       operand_ready_o;
  strb_t              mask_i;
  logic               mask_valid_i;
  logic               mask_ready_o;
  wb_payload_t        wb_o;
  logic               wb_valid_o;
  logic               wb_ready_i;
  logic [NrVInsn-1:0] done_o;

  integer      seed;
  integer      bp_rnd;
  logic        bp_en;
  elen_t       vs1_words [$];
  elen_t       vs2_words [$];
  elen_t       vd_words [$];
  strb_t       mask_words [$];
  elen_t       vs1_data, vs2_data, vd_data;
  logic        vs1_valid, vs2_valid, vd_valid;
  vid_t        next_id;
  string       cur_test;
  int unsigned cycle_cnt, cycle_limit, words_sent, insn_sent;
  int unsigned tests_run, tb_err, err_base, words_base, full_base;
  int unsigned err_cnt, word_cnt, done_cnt, full_cycles, pending;

  assign operand_i       = {vd_data, vs2_data, vs1_data};
  assign operand_valid_i = {vd_valid, vs2_valid, vs1_valid};

  vmul_lane #(
    .InsnQueueDepth(InsnQueueDepth),
    .RegWords      (RegWords)
  ) UUT (
    .clk_i, .rst_ni, .insn_i, .insn_valid_i, .insn_ready_o, .operand_i, .operand_valid_i,
    .operand_ready_o, .mask_i, .mask_valid_i, .mask_ready_o, .wb_o, .wb_valid_o, .wb_ready_i,
    .done_o
  );

  vmul_lane_checker #(
    .InsnQueueDepth(InsnQueueDepth),
    .RegWords      (RegWords)
  ) i_checker (
    .clk_i, .rst_ni, .insn_i, .insn_valid_i, .insn_ready_i(insn_ready_o), .operand_i,
    .operand_valid_i, .operand_ready_i(operand_ready_o), .mask_i, .mask_valid_i,
    .mask_ready_i(mask_ready_o), .wb_i(wb_o), .wb_valid_i(wb_valid_o), .wb_ready_i,
    .done_i(done_o),
    .err_cnt_o(err_cnt), .word_cnt_o(word_cnt), .done_cnt_o(done_cnt),
    .full_cycles_o(full_cycles), .pending_o(pending)
  );

  initial clk_i = 1'b0;
  always #2 clk_i = ~clk_i;

  // Operand feeders present each queue's next word until the DUT takes it
  always @(posedge clk_i) begin
    if (vs1_valid && operand_ready_o[0]) void'(vs1_words.pop_front());
    #1;
    vs1_valid = (vs1_words.size() != 0);
    if (vs1_valid) vs1_data = vs1_words[0];
  end

  always @(posedge clk_i) begin
    if (vs2_valid && operand_ready_o[1]) void'(vs2_words.pop_front());
    #1;
    vs2_valid = (vs2_words.size() != 0);
    if (vs2_valid) vs2_data = vs2_words[0];
  end

  always @(posedge clk_i) begin
    if (vd_valid && operand_ready_o[2]) void'(vd_words.pop_front());
    #1;
    vd_valid = (vd_words.size() != 0);
    if (vd_valid) vd_data = vd_words[0];
  end

  always @(posedge clk_i) begin
    if (mask_valid_i && mask_ready_o) void'(mask_words.pop_front());
    #1;
    mask_valid_i = (mask_words.size() != 0);
    if (mask_valid_i) mask_i = mask_words[0];
  end

  // Drawn at the edge, applied just after it
  always @(posedge clk_i) begin
    bp_rnd = bp_en ? $random(seed) : 1;
    #1;
    wb_ready_i = bp_rnd[0];
  end

  // Limit grows with every word handed to the DUT
  always @(posedge clk_i) begin
    cycle_cnt++;
    if (cycle_cnt > cycle_limit) begin
      $display("Timeout: run stopped after %0d cycles, %0d of %0d instructions done",
               cycle_cnt, done_cnt, insn_sent);
      $display("Test failed");
      $finish;
    end
  end

  task automatic send_insn(vmul_op_e op, vew_e vew, vlen_t vl, logic [4:0] vd,
                           logic use_scalar, logic vm);
    vmul_insn_t  insn;
    int unsigned epw;
    int unsigned nwords;
    epw             = 8 >> int'(vew);
    nwords          = (int'(vl) + epw - 1) / epw;
    insn.id         = next_id;
    insn.op         = op;
    insn.vew        = vew;
    insn.vl         = vl;
    insn.vd         = vd;
    insn.use_scalar = use_scalar;
    insn.scalar     = {$random(seed), $random(seed)};
    insn.vm         = vm;
    next_id++;
    for (int w = 0; w < nwords; w++) begin
      if (!use_scalar) vs1_words.push_back({$random(seed), $random(seed)});
      vs2_words.push_back({$random(seed), $random(seed)});
      if (op == VMACC) vd_words.push_back({$random(seed), $random(seed)});
      if (!vm) mask_words.push_back(strb_t'($random(seed)));
    end
    words_sent += nwords;
    insn_sent++;
    cycle_limit = 200 + 40 * words_sent;
    insn_i       = insn;
    insn_valid_i = 1'b1;
    @(posedge clk_i);
    while (!insn_ready_o) @(posedge clk_i);
    #1;
    insn_valid_i = 1'b0;
  endtask

  task automatic begin_test(string name, logic back_pressure);
    cur_test             = name;
    i_checker.test_name  = name;
    bp_en                = back_pressure;
    words_base           = words_sent;
  endtask

  task automatic end_test();
    while (done_cnt != insn_sent) begin
      @(posedge clk_i);
      #1;
    end
    repeat (4) @(posedge clk_i);
    #1;
    tests_run++;
    $display("%-13s %0d words, %0d errors", cur_test, words_sent - words_base,
             err_cnt + tb_err - err_base);
    err_base = err_cnt + tb_err;
  endtask

  initial begin
    seed         = 32'h49f26f89;
    rst_ni       = 1'b0;
    insn_i       = '0;
    insn_valid_i = 1'b0;
    vs1_data     = '0;
    vs2_data     = '0;
    vd_data      = '0;
    vs1_valid    = 1'b0;
    vs2_valid    = 1'b0;
    vd_valid     = 1'b0;
    mask_i       = '0;
    mask_valid_i = 1'b0;
    wb_ready_i   = 1'b0;
    bp_en        = 1'b0;
    next_id      = '0;
    cycle_cnt    = 0;
    cycle_limit  = 200;
    words_sent   = 0;
    insn_sent    = 0;
    tests_run    = 0;
    tb_err       = 0;
    err_base     = 0;
    repeat (5) @(posedge clk_i);
    #1 rst_ni = 1'b1;

    begin_test("vmul_ew64", 1'b0);
    send_insn(VMUL, EW64, 11'd5, 5'd3, 1'b0, 1'b1);
    end_test();

    begin_test("vmul_tail", 1'b0);
    send_insn(VMUL, EW8, 11'd13, 5'd1, 1'b0, 1'b1);
    send_insn(VMUL, EW16, 11'd7, 5'd2, 1'b0, 1'b1);
    send_insn(VMUL, EW32, 11'd3, 5'd4, 1'b0, 1'b1);
    end_test();

    begin_test("scalar_ops", 1'b0);
    send_insn(VMULHU, EW16, 11'd9, 5'd5, 1'b1, 1'b1);
    send_insn(VMACC, EW32, 11'd5, 5'd6, 1'b1, 1'b1);
    send_insn(VMACC, EW8, 11'd19, 5'd7, 1'b1, 1'b1);
    send_insn(VMULHU, EW64, 11'd2, 5'd8, 1'b0, 1'b1);
    end_test();

    begin_test("masked", 1'b1);
    send_insn(VMUL, EW8, 11'd20, 5'd9, 1'b0, 1'b0);
    send_insn(VMACC, EW64, 11'd3, 5'd10, 1'b0, 1'b0);
    send_insn(VMULHU, EW32, 11'd6, 5'd11, 1'b1, 1'b0);
    end_test();

    begin_test("back_to_back", 1'b1);
    full_base = full_cycles;
    send_insn(VMUL, EW8, 11'd30, 5'd12, 1'b0, 1'b1);
    send_insn(VMACC, EW64, 11'd4, 5'd13, 1'b0, 1'b1);
    send_insn(VMULHU, EW16, 11'd10, 5'd14, 1'b0, 1'b0);
    send_insn(VMUL, EW32, 11'd7, 5'd15, 1'b1, 1'b1);
    send_insn(VMACC, EW8, 11'd11, 5'd16, 1'b1, 1'b1);
    if (full_cycles == full_base) begin
      $display("ERROR: insn_ready_o never dropped with four instructions in flight");
      tb_err++;
    end
    end_test();

    if (pending != 0 || vs1_words.size() != 0 || vs2_words.size() != 0 ||
        vd_words.size() != 0 || mask_words.size() != 0) begin
      $display("ERROR: operand words or expected results left over at the end of the run");
      tb_err++;
    end
    $display("Totals: %0d tests, %0d instructions, %0d words checked, %0d done pulses, %0d errors",
             tests_run, insn_sent, word_cnt, done_cnt, err_cnt + tb_err);
    if (err_cnt + tb_err == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// ==== vmul_lane.f ====
vmul_lane_pkg.sv
vinsn_queue.sv
vmul_issue.sv
simd_mul.sv
result_queue.sv
vmul_writeback.sv
vmul_lane.sv
vmul_lane_checker.sv
tb_vmul_lane.sv
